// File: design/divArithPkg.sv
package divArithPkg;

    ////////////////////////////////////////////////////////////////////////////
    // operand widths
    ////////////////////////////////////////////////////////////////////////////

    // dividend is a mantissa pair product width
    // 24 bit mantissa shifted up by 23 places
    localparam int DividendWidth = 47;

    // divisor width, the quotient has the same width
    localparam int DivisorWidth = 24;

    // partial remainder holds one extra bit above the divisor
    localparam int RemainderWidth = DivisorWidth + 1;

    ////////////////////////////////////////////////////////////////////////////
    // value types
    ////////////////////////////////////////////////////////////////////////////

    // full dividend as presented at the top level
    typedef logic [DividendWidth-1:0] dividendT;

    // divisor mantissa
    typedef logic [DivisorWidth-1:0] divisorT;

    // one quotient bit per restoring row
    typedef logic [DivisorWidth-1:0] quotientT;

    // shifted remainder before and after each row
    // top bit only matters inside a row
    typedef logic [RemainderWidth-1:0] remainderT;

endpackage

// File: design/divPipePkg.sv
package divPipePkg;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline organisation
    ////////////////////////////////////////////////////////////////////////////

    // restoring rows evaluated between two registers
    // must divide the quotient width evenly
    localparam int RowsPerStage = 6;

    // number of registered row groups
    localparam int StageCount = divArithPkg::DivisorWidth / RowsPerStage;

    // cycles from the edge that samples inValid to outValid high
    // one for operand capture, one per row stage, one for the output
    localparam int Latency = StageCount + 2;

endpackage

// File: design/divStageIf.sv
`timescale 1ns/1ps

// state of one division as it moves down the pipeline
interface divStageIf;

    // marks a live division in this slot
    logic valid;

    // partial remainder after the last row evaluated
    divArithPkg::remainderT remainder;

    // dividend travels along so later rows can pick their bit
    divArithPkg::dividendT dividend;

    // divisor is reused by every row
    divArithPkg::divisorT divisor;

    // quotient bits so far, newest bit at the low end
    divArithPkg::quotientT quotient;

    // zero over zero, detected once at capture
    logic zeroCase;

    // driving stage
    modport producer (
        output valid,
        output remainder,
        output dividend,
        output divisor,
        output quotient,
        output zeroCase
    );

    // reading stage
    modport consumer (
        input valid,
        input remainder,
        input dividend,
        input divisor,
        input quotient,
        input zeroCase
    );

endinterface

// File: design/operandCapture.sv
`timescale 1ns/1ps

module operandCapture (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inValid,
    input  divArithPkg::dividendT dividend,
    input  divArithPkg::divisorT  divisor,
    divStageIf.producer          stageOut
);

    localparam int DivW = divArithPkg::DivisorWidth;
    localparam int DvdW = divArithPkg::DividendWidth;

    ////////////////////////////////////////////////////////////////////////////
    // first row
    ////////////////////////////////////////////////////////////////////////////

    // top 24 dividend bits against the divisor
    // no bit above them, so the row is only DivW wide
    logic [DivW-1:0] topBits;
    logic [DivW:0]   firstSum;
    logic            firstCarry;
    logic [DivW-1:0] firstRem;

    assign topBits = dividend[DvdW-1 -: DivW];

    // two's complement subtract, carry out set when topBits >= divisor
    assign firstSum = {1'b0, topBits} + {1'b0, ~divisor} + (DivW + 1)'(1);
    assign firstCarry = firstSum[DivW];

    // keep the difference only when the subtract did not borrow
    assign firstRem = firstCarry ? firstSum[DivW-1:0] : topBits;

    ////////////////////////////////////////////////////////////////////////////
    // capture register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stageOut.valid <= 1'b0;
        end else begin
            stageOut.valid <= inValid;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        stageOut.remainder <= {1'b0, firstRem};
        stageOut.dividend  <= dividend;
        stageOut.divisor   <= divisor;
        // first quotient bit lands at the bottom and moves up row by row
        stageOut.quotient  <= {{(DivW-1){1'b0}}, firstCarry};
        // zero over zero gives zero and not all ones
        stageOut.zeroCase  <= (dividend == '0) && (divisor == '0);
    end

endmodule

// File: design/divRowStage.sv
`timescale 1ns/1ps

module divRowStage #(
    parameter int RowsPerStage = 6,
    parameter int StageIndex   = 0
) (
    input  logic        clk,
    input  logic        reset,
    divStageIf.consumer stageIn,
    divStageIf.producer stageOut
);

    localparam int DivW = divArithPkg::DivisorWidth;
    localparam int DvdW = divArithPkg::DividendWidth;

    // global number of the first row here
    // row 0 lives in operand capture
    localparam int FirstRow = 1 + StageIndex * RowsPerStage;

    ////////////////////////////////////////////////////////////////////////////
    // row chain
    ////////////////////////////////////////////////////////////////////////////

    // entry j feeds row j, last entry goes to the register
    divArithPkg::remainderT remChain [RowsPerStage+1];
    divArithPkg::quotientT  quoChain [RowsPerStage+1];

    assign remChain[0] = stageIn.remainder;
    assign quoChain[0] = stageIn.quotient;

    for (genvar j = 0; j < RowsPerStage; j++) begin : rowGen

        localparam int RowNum = FirstRow + j;

        if (RowNum < DivW) begin : activeRow
            logic [DivW:0]   shifted;
            logic [DivW+1:0] rowSum;
            logic            rowCarry;

            // bring down the next dividend bit
            // row n consumes bit 23 - n of the dividend
            assign shifted = {remChain[j][DivW-1:0], stageIn.dividend[DvdW - DivW - RowNum]};

            // subtract the zero extended divisor
            assign rowSum = {1'b0, shifted} + {1'b0, ~{1'b0, stageIn.divisor}}
                          + (DivW + 2)'(1);
            assign rowCarry = rowSum[DivW+1];

            // restore on borrow
            assign remChain[j+1] = rowCarry ? rowSum[DivW:0] : shifted;

            // carry out is the quotient bit
            assign quoChain[j+1] = {quoChain[j][DivW-2:0], rowCarry};
        end else begin : idleRow
            // past the last dividend bit
            // only happens in the final stage
            assign remChain[j+1] = remChain[j];
            assign quoChain[j+1] = quoChain[j];
        end

    end

    ////////////////////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stageOut.valid <= 1'b0;
        end else begin
            stageOut.valid <= stageIn.valid;
        end
    end

    // data follows the valid flag with no reset
    always_ff @(posedge clk) begin
        stageOut.remainder <= remChain[RowsPerStage];
        stageOut.quotient  <= quoChain[RowsPerStage];
        stageOut.dividend  <= stageIn.dividend;
        stageOut.divisor   <= stageIn.divisor;
        stageOut.zeroCase  <= stageIn.zeroCase;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // exactly one cycle through the stage, no slot lost or added
    validDelayCheck: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> (stageOut.valid == $past(stageIn.valid))
    ) else $error("divRowStage %0d valid out of step with its input", StageIndex);

endmodule

// File: design/quotientAssemble.sv
`timescale 1ns/1ps

module quotientAssemble (
    input  logic                  clk,
    input  logic                  reset,
    divStageIf.consumer           stageIn,
    output logic                  outValid,
    output divArithPkg::quotientT quotient
);

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    // one pulse per division, no hold
    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= stageIn.valid;
        end
    end

    // zero over zero
    // rows alone would give all ones here
    always_ff @(posedge clk) begin
        if (stageIn.zeroCase) begin
            quotient <= '0;
        end else begin
            quotient <= stageIn.quotient;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // first cycle out of reset, the whole pipe behind us must still be empty
    outIdleAfterReset: assert property (
        @(posedge clk)
        $fell(reset) |=> (outValid == 1'b0)
    ) else $error("outValid high in the cycle after reset");

    // outValid must be known once the pipe is out of reset
    outValidKnown: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(outValid)
    ) else $error("outValid is unknown");

endmodule

// File: design/arrayDivider.sv
`timescale 1ns/1ps

module arrayDivider #(
    parameter int RowsPerStage = divPipePkg::RowsPerStage
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inValid,
    input  divArithPkg::dividendT dividend,
    input  divArithPkg::divisorT  divisor,
    output logic                  outValid,
    output divArithPkg::quotientT quotient
);

    // row groups for the chosen stage depth
    localparam int StageCount = divArithPkg::DivisorWidth / RowsPerStage;

    ////////////////////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////////////////////

    // link 0 leaves capture, link StageCount enters the output
    divStageIf stageLink [StageCount+1] ();

    ////////////////////////////////////////////////////////////////////////////
    // pipeline
    ////////////////////////////////////////////////////////////////////////////

    // operands in, row 0 done
    operandCapture capture (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .dividend (dividend),
        .divisor  (divisor),
        .stageOut (stageLink[0])
    );

    // remaining rows, RowsPerStage per register
    for (genvar s = 0; s < StageCount; s++) begin : stageGen
        divRowStage #(
            .RowsPerStage (RowsPerStage),
            .StageIndex   (s)
        ) rowStage (
            .clk      (clk),
            .reset    (reset),
            .stageIn  (stageLink[s]),
            .stageOut (stageLink[s+1])
        );
    end

    // zero case and result register
    quotientAssemble assemble (
        .clk      (clk),
        .reset    (reset),
        .stageIn  (stageLink[StageCount]),
        .outValid (outValid),
        .quotient (quotient)
    );

endmodule

// File: dv/divCheckTasks.svh
////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

// quotient against the value from the golden file
task automatic checkQuotient(input string name, input divArithPkg::quotientT actual,
                             input divArithPkg::quotientT expected);
    if (actual !== expected) begin
        failRun($sformatf("error: %s is %h, expected %h", name, actual, expected));
    end
endtask

// single valid flag, also catches x and z
task automatic checkValid(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        failRun($sformatf("error: %s is %h, expected %h", name, actual, expected));
    end
endtask

// latency in cycles
task automatic checkCount(input string name, input int actual, input int expected);
    if (actual != expected) begin
        failRun($sformatf("error: %s is %h, expected %h", name, actual, expected));
    end
endtask

////////////////////////////////////////////////////////////////////////////
// waits
////////////////////////////////////////////////////////////////////////////

// until every division in flight has come out
// rising edge, so the monitor has already popped on the falling edge before
task automatic waitForDrain(input int limit);
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < limit) begin
        @(posedge clk);
        waited++;
    end
    if (expQ.size() != 0) begin
        failRun("timed out waiting for the outstanding quotients to come out");
    end
endtask

// File: dv/arrayDividerTb.sv
`timescale 1ns/1ps

module arrayDividerTb;

    localparam int ClkPeriod   = 100;
    localparam int DriveDelay  = 5;
    localparam int ResetCycles = 8;
    localparam int MaxGap      = 3;
    localparam int DrainLimit  = 4 * divPipePkg::Latency;
    localparam     GoldenFile  = "dv/divGolden.txt";

    logic                  clk;
    logic                  reset;
    logic                  inValid;
    divArithPkg::dividendT dividend;
    divArithPkg::divisorT  divisor;
    logic                  outValid;
    divArithPkg::quotientT quotient;

    // vectors as read from the golden file
    divArithPkg::dividendT vecDividend [$];
    divArithPkg::divisorT  vecDivisor [$];
    divArithPkg::quotientT vecQuotient [$];

    // scoreboard, expected quotient and the edge that sampled it
    divArithPkg::quotientT expQ [$];
    int                    sampledAt [$];

    int cycle        = 0;
    int releaseCycle = 0;
    int seed         = 83526;
    int gap;

    arrayDivider #(
        .RowsPerStage (divPipePkg::RowsPerStage)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .dividend (dividend),
        .divisor  (divisor),
        .outValid (outValid),
        .quotient (quotient)
    );

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    `include "divCheckTasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // clock and cycle count
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // lines starting with a slash are comments
    task automatic loadGolden();
        int fd;
        int n;
        string line;
        divArithPkg::dividendT a;
        divArithPkg::divisorT  b;
        divArithPkg::quotientT q;
        fd = $fopen(GoldenFile, "r");
        if (fd == 0) begin
            failRun("could not open the golden vector file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "/") begin
                n = $sscanf(line, "%h %h %h", a, b, q);
                if (n == 3) begin
                    vecDividend.push_back(a);
                    vecDivisor.push_back(b);
                    vecQuotient.push_back(q);
                end
            end
        end
        $fclose(fd);
        if (vecDividend.size() == 0) begin
            failRun("the golden vector file holds no vectors");
        end
    endtask

    // one operand pair, sampled on the next rising edge
    task automatic driveVector(input int idx);
        @(posedge clk);
        #DriveDelay;
        inValid  = 1'b1;
        dividend = vecDividend[idx];
        divisor  = vecDivisor[idx];
        expQ.push_back(vecQuotient[idx]);
        sampledAt.push_back(cycle + 1);
    endtask

    task automatic driveIdle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #DriveDelay;
            inValid = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////

    // falling edge, outputs settled
    // nothing is registered before the first rising edge
    always @(negedge clk) begin
        if (cycle > 0) begin
            if (reset || cycle <= releaseCycle + 2) begin
                checkValid("outValid", outValid, 1'b0);
            end else if (outValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    failRun("outValid pulsed with no division in flight");
                end else begin
                    checkQuotient("quotient", quotient, expQ.pop_front());
                    // register edges from capture to output, both ends counted
                    checkCount("outValid latency", cycle - sampledAt.pop_front() + 1,
                               divPipePkg::Latency);
                end
            end else begin
                checkValid("outValid", outValid, 1'b0);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset    = 1'b1;
        inValid  = 1'b0;
        dividend = '0;
        divisor  = '0;
        loadGolden();

        for (int i = 0; i < ResetCycles; i++) begin
            @(posedge clk);
        end
        #DriveDelay;
        reset        = 1'b0;
        releaseCycle = cycle;
        // quiet cycle after reset
        driveIdle(1);

        // back to back, one division per cycle
        for (int i = 0; i < vecDividend.size(); i++) begin
            driveVector(i);
        end
        driveIdle(1);
        waitForDrain(DrainLimit);

        // same vectors with random idle gaps
        for (int i = 0; i < vecDividend.size(); i++) begin
            gap = $random(seed) & MaxGap;
            driveIdle(gap);
            driveVector(i);
        end
        driveIdle(1);
        waitForDrain(DrainLimit);

        // quiet tail, a late extra pulse still reaches the monitor
        driveIdle(divPipePkg::Latency);

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: dv/divGolden.txt
// columns: dividend (47 bits), divisor (24 bits), expected quotient (24 bits), all hex
// one division per line, lines starting with a slash are skipped
// normalized mantissa pairs, dividend is the mantissa shifted up by 23
400000000000 800000 800000
600000000000 800000 c00000
700000000000 800000 e00000
400000000000 c00000 555555
600000000000 a00000 999999
480000000000 c00000 600000
400000000000 e00000 492492
500000000000 c00000 6aaaaa
7fffff800000 ffffff 800000
7fffff800000 800001 fffffd
// quotient range limits
7fffff800000 800000 ffffff
400000000000 ffffff 400000
7fffffffffff 800000 ffffff
7fffffffffff ffffff 800000
000000000005 000006 000000
000000000001 ffffff 000000
000000ffffff ffffff 000001
// small operands
000000000064 000007 00000e
000000000064 00000a 00000a
000000010000 000100 000100
000000000001 000001 000001
000000123456 000002 091a2b
000000123457 000010 012345
0000ffffffff 000100 ffffff
000100000000 000101 ff00ff
000003000000 000004 c00000
// zero dividend
000000000000 c00000 000000
000000000000 000001 000000
// zero divisor, every row selects
400000000000 000000 ffffff
000000000001 000000 ffffff
7fffffffffff 000000 ffffff
// both zero
000000000000 000000 000000

// File: arrayDivider.f
+incdir+dv
design/divArithPkg.sv
design/divPipePkg.sv
design/divStageIf.sv
design/operandCapture.sv
design/divRowStage.sv
design/quotientAssemble.sv
design/arrayDivider.sv
dv/arrayDividerTb.sv
